// ==== design/image_pkg.sv ====
package image_pkg;

  // Source frame size
  localparam int frame_width  = 16;
  localparam int frame_height = 12;
  localparam int frame_pixels = frame_width * frame_height;

  // Size after the 2x2 down sampler
  localparam int low_width  = frame_width / 2;
  localparam int low_height = frame_height / 2;

  // One grey sample
  typedef logic [7:0] pixel_t;

  // Meaning of the one-bit mode input
  localparam logic mode_raw      = 1'b0;
  localparam logic mode_filtered = 1'b1;

endpackage

// ==== design/mem_pkg.sv ====
package mem_pkg;

  localparam int addr_width      = 18;
  localparam int data_width      = 32;
  localparam int pixels_per_word = data_width / $bits(image_pkg::pixel_t);

  // Words needed for one full frame
  localparam int frame_words = image_pkg::frame_pixels / pixels_per_word;

  typedef logic [addr_width-1:0] word_addr_t;
  typedef logic [data_width-1:0] word_data_t;

endpackage

// ==== design/pixel_stream_if.sv ====
`timescale 1ns/1ps

interface pixel_stream_if;

  logic                  valid;  // One strobe per pixel
  image_pkg::pixel_t     pixel;
  logic                  first;  // First pixel of a frame
  logic                  last;   // Final pixel of a frame

  modport source (
    output valid,
    output pixel,
    output first,
    output last
  );

  modport sink (
    input valid,
    input pixel,
    input first,
    input last
  );

endinterface

// ==== design/static_image_source.sv ====
`timescale 1ns/1ps

module static_image_source (
  input  logic           clock,
  input  logic           rst_n,
  input  logic           start,
  pixel_stream_if.source out
);

  logic                                          active;
  logic [$clog2(image_pkg::frame_width)-1:0]     x;
  logic [$clog2(image_pkg::frame_height)-1:0]    y;
  image_pkg::pixel_t                             x_term;
  image_pkg::pixel_t                             y_term;

  // Raster counter ignores start while a frame is running
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      active <= 1'b0;
      x      <= '0;
      y      <= '0;
    end else if (!active) begin
      if (start) begin
        active <= 1'b1;
        x      <= '0;
        y      <= '0;
      end
    end else if (x == image_pkg::frame_width - 1) begin
      x <= '0;
      if (y == image_pkg::frame_height - 1)
        active <= 1'b0;  // Frame complete
      else
        y <= y + 1'b1;
    end else begin
      x <= x + 1'b1;
    end
  end

  // Pattern 13x + 7y wraps at 256
  assign x_term = 8'(x) * 8'd13;
  assign y_term = 8'(y) * 8'd7;

  assign out.valid = active;
  assign out.pixel = x_term + y_term;
  assign out.first = active && (x == 0) && (y == 0);
  assign out.last  = active && (x == image_pkg::frame_width - 1) &&
                     (y == image_pkg::frame_height - 1);

endmodule

// ==== design/down_sampler.sv ====
`timescale 1ns/1ps

module down_sampler (
  input  logic           clock,
  input  logic           rst_n,
  pixel_stream_if.sink   in,
  pixel_stream_if.source out
);

  logic [$clog2(image_pkg::frame_width)-1:0]  x_cnt;
  logic [$clog2(image_pkg::frame_width)-1:0]  cur_x;
  logic [$clog2(image_pkg::frame_height)-1:0] y_cnt;
  logic [$clog2(image_pkg::frame_height)-1:0] cur_y;
  logic [$clog2(image_pkg::low_width)-1:0]    col;
  image_pkg::pixel_t                          held;
  logic [8:0]                                 pair_sum;
  logic [8:0]                                 line_buf [image_pkg::low_width];
  logic [9:0]                                 block_sum;
  logic                                       emit;

  // First forces the bus position back to the origin
  assign cur_x = in.first ? '0 : x_cnt;
  assign cur_y = in.first ? '0 : y_cnt;
  assign col   = cur_x[$bits(cur_x)-1:1];

  assign pair_sum  = {1'b0, held} + {1'b0, in.pixel};
  assign block_sum = {1'b0, line_buf[col]} + {1'b0, pair_sum};
  assign emit      = in.valid && cur_x[0] && cur_y[0];  // Odd pixel of odd line

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      x_cnt <= '0;
      y_cnt <= '0;
    end else if (in.valid) begin
      if (cur_x == image_pkg::frame_width - 1) begin
        x_cnt <= '0;
        y_cnt <= cur_y + 1'b1;
      end else begin
        x_cnt <= cur_x + 1'b1;
        y_cnt <= cur_y;
      end
    end
  end

  // Even pixel is held and even lines store pair sums
  always_ff @(posedge clock) begin
    if (in.valid) begin
      if (!cur_x[0])
        held <= in.pixel;
      else if (!cur_y[0])
        line_buf[col] <= pair_sum;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      out.valid <= 1'b0;
      out.first <= 1'b0;
      out.last  <= 1'b0;
    end else begin
      out.valid <= emit;
      out.first <= emit && (col == 0) && (cur_y == 1);
      out.last  <= emit && (col == image_pkg::low_width - 1) &&
                   (cur_y == image_pkg::frame_height - 1);
    end
  end

  always_ff @(posedge clock) begin
    if (emit)
      out.pixel <= block_sum[9:2];  // Divide by 4
  end

endmodule

// ==== design/row_blur_filter.sv ====
`timescale 1ns/1ps

module row_blur_filter (
  input  logic           clock,
  input  logic           rst_n,
  pixel_stream_if.sink   in,
  pixel_stream_if.source out
);

  logic [$clog2(image_pkg::low_width)-1:0]  col;
  logic [$clog2(image_pkg::low_width)-1:0]  cur_col;
  logic [$clog2(image_pkg::low_height)-1:0] row;
  logic [$clog2(image_pkg::low_height)-1:0] cur_row;
  image_pkg::pixel_t                        left;
  image_pkg::pixel_t                        center;
  image_pkg::pixel_t                        right;
  logic [9:0]                               tap_sum;
  logic                                     tail_pending;  // Last output of a line owed
  logic                                     tail_last;
  logic                                     emit;

  assign cur_col = in.first ? '0 : col;
  assign cur_row = in.first ? '0 : row;

  // Right edge repeats the center pixel
  assign right   = in.valid ? in.pixel : center;
  assign tap_sum = {2'b0, left} + {1'b0, center, 1'b0} + {2'b0, right};
  assign emit    = in.valid ? (cur_col != 0) : tail_pending;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      col          <= '0;
      row          <= '0;
      tail_pending <= 1'b0;
      tail_last    <= 1'b0;
      out.valid    <= 1'b0;
      out.first    <= 1'b0;
      out.last     <= 1'b0;
    end else begin
      out.valid <= emit;
      out.first <= in.valid && (cur_col == 1) && (cur_row == 0);
      out.last  <= !in.valid && tail_pending && tail_last;
      if (in.valid) begin
        if (cur_col == image_pkg::low_width - 1) begin
          col          <= '0;
          row          <= cur_row + 1'b1;
          tail_pending <= 1'b1;
          tail_last    <= (cur_row == image_pkg::low_height - 1);
        end else begin
          col <= cur_col + 1'b1;
          row <= cur_row;
        end
      end else if (tail_pending) begin
        tail_pending <= 1'b0;  // Flushed in the idle slot
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in.valid) begin
      left   <= (cur_col == 0) ? in.pixel : center;  // Left edge replication
      center <= in.pixel;
    end
    if (emit)
      out.pixel <= tap_sum[9:2];
  end

endmodule

// ==== design/up_sampler.sv ====
`timescale 1ns/1ps

module up_sampler (
  input  logic           clock,
  input  logic           rst_n,
  pixel_stream_if.sink   in,
  pixel_stream_if.source out
);

  image_pkg::pixel_t                        line_mem [2 * image_pkg::low_width];
  logic [$clog2(image_pkg::low_width)-1:0]  wr_col;
  logic [$clog2(image_pkg::low_width)-1:0]  cur_col;
  logic [$clog2(image_pkg::low_height)-1:0] wr_row;
  logic [$clog2(image_pkg::low_height)-1:0] cur_row;
  logic [$clog2(image_pkg::low_height)-1:0] rd_row;
  logic                                     wr_bank;
  logic                                     rd_bank;
  logic                                     rd_active;
  logic [$clog2(image_pkg::low_width)+1:0]  rd_cnt;  // Line repeat, column and pixel repeat
  logic                                     line_done;

  assign cur_col   = in.first ? '0 : wr_col;
  assign cur_row   = in.first ? '0 : wr_row;
  assign line_done = in.valid && (cur_col == image_pkg::low_width - 1);

  // Write side
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_col  <= '0;
      wr_row  <= '0;
      wr_bank <= 1'b0;
    end else if (in.valid) begin
      if (line_done) begin
        wr_col  <= '0;
        wr_row  <= cur_row + 1'b1;
        wr_bank <= !wr_bank;  // Swap halves
      end else begin
        wr_col <= cur_col + 1'b1;
        wr_row <= cur_row;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in.valid)
      line_mem[{wr_bank, cur_col}] <= in.pixel;
  end

  // A new line takes over the read side in the cycle the old one ends
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_active <= 1'b0;
      rd_cnt    <= '0;
      rd_bank   <= 1'b0;
      rd_row    <= '0;
      out.valid <= 1'b0;
      out.first <= 1'b0;
      out.last  <= 1'b0;
    end else begin
      out.valid <= rd_active;
      out.first <= rd_active && (rd_cnt == 0) && (rd_row == 0);
      out.last  <= rd_active && (&rd_cnt) && (rd_row == image_pkg::low_height - 1);
      if (line_done) begin
        rd_active <= 1'b1;
        rd_cnt    <= '0;
        rd_bank   <= wr_bank;
        rd_row    <= cur_row;
      end else if (rd_active) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (&rd_cnt)
          rd_active <= 1'b0;  // 32 pixels sent
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_active)
      out.pixel <= line_mem[{rd_bank, rd_cnt[$clog2(image_pkg::low_width):1]}];
  end

endmodule

// ==== design/image_buffer_writer.sv ====
`timescale 1ns/1ps

module image_buffer_writer (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                start,
  input  logic                mode,
  pixel_stream_if.sink        raw,
  pixel_stream_if.sink        filtered,
  output logic                write_valid,
  output mem_pkg::word_addr_t write_addr,
  output mem_pkg::word_data_t write_data,
  output logic                done
);

  logic                                          busy;
  logic                                          mode_q;
  logic                                          use_filtered;
  logic                                          take;
  image_pkg::pixel_t                             pix;
  logic                                          pix_first;
  logic                                          pix_last;
  logic [$clog2(mem_pkg::pixels_per_word)-1:0]   pix_cnt;
  logic [$clog2(mem_pkg::pixels_per_word)-1:0]   cur_cnt;
  mem_pkg::word_addr_t                           word_cnt;
  logic                                          last_pix;  // Word in flight ends the frame
  logic                                          frame_end;

  assign use_filtered = (mode_q == image_pkg::mode_filtered);
  assign take      = busy && (use_filtered ? filtered.valid : raw.valid);
  assign pix       = use_filtered ? filtered.pixel : raw.pixel;
  assign pix_first = use_filtered ? filtered.first : raw.first;
  assign pix_last  = use_filtered ? filtered.last : raw.last;
  assign cur_cnt   = pix_first ? '0 : pix_cnt;
  assign frame_end = write_valid && last_pix;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      mode_q      <= image_pkg::mode_raw;
      pix_cnt     <= '0;
      word_cnt    <= '0;
      last_pix    <= 1'b0;
      write_valid <= 1'b0;
      write_addr  <= '0;
      done        <= 1'b0;
    end else begin
      write_valid <= take && (cur_cnt == mem_pkg::pixels_per_word - 1);
      done        <= frame_end;
      if (start && (!busy || frame_end)) begin
        busy   <= 1'b1;
        mode_q <= mode;  // Held for the whole frame
      end else if (frame_end) begin
        busy <= 1'b0;
      end
      if (take) begin
        pix_cnt  <= cur_cnt + 1'b1;
        last_pix <= pix_last;
        if (pix_first)
          word_cnt <= '0;
        if (cur_cnt == mem_pkg::pixels_per_word - 1) begin
          write_addr <= word_cnt;
          word_cnt   <= word_cnt + 1'b1;
        end
      end
    end
  end

  // Lowest x ends up in bits 7:0
  always_ff @(posedge clock) begin
    if (take)
      write_data <= {pix, write_data[mem_pkg::data_width-1:$bits(pix)]};
  end

endmodule

// ==== design/image_pipeline_top.sv ====
`timescale 1ns/1ps

module image_pipeline_top (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                start,
  input  logic                mode,
  output logic                write_valid,
  output mem_pkg::word_addr_t write_addr,
  output mem_pkg::word_data_t write_data,
  output logic                done
);

  pixel_stream_if raw_stream ();
  pixel_stream_if low_stream ();   // 8x6 averaged
  pixel_stream_if blur_stream ();
  pixel_stream_if full_stream ();  // Back at 16x12

  static_image_source static_image_source_i (
    .clock (clock),
    .rst_n (rst_n),
    .start (start),
    .out   (raw_stream)
  );

  down_sampler down_sampler_i (
    .clock (clock),
    .rst_n (rst_n),
    .in    (raw_stream),
    .out   (low_stream)
  );

  row_blur_filter row_blur_filter_i (
    .clock (clock),
    .rst_n (rst_n),
    .in    (low_stream),
    .out   (blur_stream)
  );

  up_sampler up_sampler_i (
    .clock (clock),
    .rst_n (rst_n),
    .in    (blur_stream),
    .out   (full_stream)
  );

  image_buffer_writer image_buffer_writer_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .start       (start),
    .mode        (mode),
    .raw         (raw_stream),
    .filtered    (full_stream),
    .write_valid (write_valid),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .done        (done)
  );

endmodule

// ==== test/image_pipeline_properties.sv ====
`timescale 1ns/1ps

module image_pipeline_properties (
  input logic                clock,
  input logic                rst_n,
  input logic                start,
  input logic                mode,
  input logic                write_valid,
  input mem_pkg::word_addr_t write_addr,
  input logic                done
);

  int          failures = 0;
  logic        seen_start;
  logic        frame_open;   // Between an accepted start and its done
  logic        frame_raw;
  int unsigned since_start;  // 1 in the cycle after the accepted start
  int unsigned write_cnt;

  // A start while a frame is open does not begin a new one
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      seen_start  <= 1'b0;
      frame_open  <= 1'b0;
      frame_raw   <= 1'b0;
      since_start <= 0;
      write_cnt   <= 0;
    end else begin
      if (start)
        seen_start <= 1'b1;
      if (start && !frame_open) begin
        frame_open  <= 1'b1;
        frame_raw   <= (mode == image_pkg::mode_raw);
        since_start <= 1;
        write_cnt   <= 0;
      end else begin
        if (done)
          frame_open <= 1'b0;
        since_start <= since_start + 1;
        if (write_valid)
          write_cnt <= write_cnt + 1;
      end
    end
  end

  idle_before_start: assert property (@(posedge clock) disable iff (!rst_n)
    !seen_start |-> !write_valid && !done)
    else begin
      $error("write_valid or done went high before any start");
      failures++;
    end

  // Raw latency is 5 cycles to the first word
  raw_first_write: assert property (@(posedge clock) disable iff (!rst_n)
    frame_open && frame_raw && since_start <= 5 |-> write_valid == (since_start == 5))
    else begin
      $error("first raw write not exactly 5 cycles after start");
      failures++;
    end

  raw_done_time: assert property (@(posedge clock) disable iff (!rst_n)
    frame_open && frame_raw |-> done == (since_start == 194))
    else begin
      $error("raw done not exactly 194 cycles after start");
      failures++;
    end

  addr_sequence: assert property (@(posedge clock) disable iff (!rst_n)
    write_valid |-> frame_open && write_addr == write_cnt &&
                    write_cnt < mem_pkg::frame_words)
    else begin
      $error("write address out of sequence or write outside a frame");
      failures++;
    end

  done_after_all_words: assert property (@(posedge clock) disable iff (!rst_n)
    done |-> frame_open && write_cnt == mem_pkg::frame_words)
    else begin
      $error("done without exactly one full frame of words");
      failures++;
    end

  done_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
    done |=> !done)
    else begin
      $error("done held for more than one cycle");
      failures++;
    end

endmodule

// ==== test/tb_image_pipeline.sv ====
`timescale 1ns/1ps

module tb_image_pipeline;

  logic                clock = 1'b0;
  logic                rst_n;
  logic                start;
  logic                mode;
  logic                write_valid;
  mem_pkg::word_addr_t write_addr;
  mem_pkg::word_data_t write_data;
  logic                done;

  int unsigned         lcg_state = 70880;
  logic                frame_mode_q;  // Mode the tb launched the frame with
  int                  word_idx = 0;
  int                  data_errors = 0;
  int                  assert_failures;
  mem_pkg::word_data_t exp_word;

  always #4 clock = ~clock;

  image_pipeline_top image_pipeline_top_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .start       (start),
    .mode        (mode),
    .write_valid (write_valid),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .done        (done)
  );

  bind image_pipeline_top image_pipeline_properties properties_i (
    .clock       (clock),
    .rst_n       (rst_n),
    .start       (start),
    .mode        (mode),
    .write_valid (write_valid),
    .write_addr  (write_addr),
    .done        (done)
  );

  function automatic int unsigned idle_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % 21;  // 0 to 20 cycles
  endfunction

  function automatic logic [7:0] pattern_px(int x, int y);
    return 8'((13 * x + 7 * y) % 256);
  endfunction

  function automatic logic [7:0] low_px(int i, int j);
    int sum;
    sum = pattern_px(2 * i, 2 * j) + pattern_px(2 * i + 1, 2 * j) +
          pattern_px(2 * i, 2 * j + 1) + pattern_px(2 * i + 1, 2 * j + 1);
    return 8'(sum / 4);
  endfunction

  // 1-2-1 along the row with the edge columns clamped
  function automatic logic [7:0] blur_px(int i, int j);
    int l;
    int r;
    int sum;
    l   = (i > 0) ? i - 1 : 0;
    r   = (i < image_pkg::low_width - 1) ? i + 1 : image_pkg::low_width - 1;
    sum = low_px(l, j) + 2 * low_px(i, j) + low_px(r, j);
    return 8'(sum / 4);
  endfunction

  function automatic mem_pkg::word_data_t expected_word(logic frame_mode, int index);
    mem_pkg::word_data_t w;
    int                  x0;
    int                  y;
    y  = index / (image_pkg::frame_width / mem_pkg::pixels_per_word);
    x0 = (index % (image_pkg::frame_width / mem_pkg::pixels_per_word)) *
         mem_pkg::pixels_per_word;
    for (int k = 0; k < mem_pkg::pixels_per_word; k++) begin
      if (frame_mode == image_pkg::mode_filtered)
        w[8*k +: 8] = blur_px((x0 + k) / 2, y / 2);
      else
        w[8*k +: 8] = pattern_px(x0 + k, y);  // Lowest x in bits 7:0
    end
    return w;
  endfunction

  // Words are stable at the falling edge
  always @(negedge clock) begin
    if (rst_n && write_valid) begin
      exp_word = expected_word(frame_mode_q, word_idx);
      if (write_data !== exp_word) begin
        $display("Error at %0t ns: address %0d expected %h received %h",
                 $time, write_addr, exp_word, write_data);
        data_errors++;
      end
      word_idx++;
    end
    if (done)
      word_idx = 0;
  end

  task automatic run_frame(input logic frame_mode, input bit second_start);
    @(negedge clock);
    frame_mode_q = frame_mode;
    mode         = frame_mode;
    start        = 1'b1;
    @(negedge clock);
    start = 1'b0;
    if (second_start) begin
      repeat (100) @(negedge clock);
      mode  = image_pkg::mode_filtered;  // Must not switch the running frame
      start = 1'b1;
      @(negedge clock);
      start = 1'b0;
    end
    while (!done)
      @(negedge clock);
    // Filter path keeps running after a raw frame and needs time to drain
    repeat (48 + idle_gap()) @(negedge clock);
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    mode  = image_pkg::mode_raw;
    frame_mode_q = image_pkg::mode_raw;
    repeat (16) @(negedge clock);
    rst_n = 1'b1;
    repeat (idle_gap()) @(negedge clock);
    run_frame(image_pkg::mode_raw, 1'b0);
    run_frame(image_pkg::mode_raw, 1'b0);
    run_frame(image_pkg::mode_filtered, 1'b0);
    run_frame(image_pkg::mode_filtered, 1'b0);
    run_frame(image_pkg::mode_raw, 1'b1);
    repeat (4) @(negedge clock);
    assert_failures = image_pipeline_top_i.properties_i.failures;
    $display("Data errors: %0d, assertion failures: %0d", data_errors, assert_failures);
    if (data_errors == 0 && assert_failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // 6 frames of 400 cycles each
  initial begin
    #(6 * 400 * 8);
    $display("Timeout: the run did not reach its end in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
design/image_pkg.sv
design/mem_pkg.sv
design/pixel_stream_if.sv
design/static_image_source.sv
design/down_sampler.sv
design/row_blur_filter.sv
design/up_sampler.sv
design/image_buffer_writer.sv
design/image_pipeline_top.sv
test/image_pipeline_properties.sv
test/tb_image_pipeline.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_image_pipeline
FILELIST  = tb.f
SIM_ARGS  = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = *** PASSED ***

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
